// ==== fw_ip1.f ====
fw_ip1_pkg.sv
fw_op_decoder.sv
fw_cfg_regs.sv
fw_configclk_gen.sv
fw_cfg_chain_test.sv
fw_readout.sv
fw_ip1.sv
tb_fw_ip1.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the fw_ip1 testbench with Verilator, pass or fail from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_fw_ip1 \
  -f fw_ip1.f -o sim_fw_ip1 \
  && ./obj_dir/sim_fw_ip1 > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Simulation completed successfully" sim.log && exit 0 || exit 1

// ==== tb_fw_ip1.sv ====
//------------------------------------------------------------
// IP1 slow control testbench
// Drives opcode pulses on the falling edge, runs the config
// chain test in loopback and chip mode, checks with assertions
//------------------------------------------------------------
`timescale 1ns/1ps

module tb_fw_ip1 import fw_ip1_pkg::*; ();

  // Opcode selectors for issue_op
  localparam int OP_W_RESET        = 0;
  localparam int OP_W_STATIC       = 1;
  localparam int OP_R_STATIC       = 2;
  localparam int OP_W_ARRAY        = 3;
  localparam int OP_R_ARRAY        = 4;
  localparam int OP_R_DATA         = 5;
  localparam int OP_W_STATUS_CLEAR = 6;
  localparam int OP_EXECUTE        = 7;

  localparam int TB_PERIOD  = 8;                  // Config clock period in fw_axi_clk cycles
  localparam int TB_DELAY   = 4;
  localparam int TB_SAMPLE  = 6;                  // After the delay, before the wrap
  localparam int RUN_CYCLES = TB_DELAY + TB_PERIOD * (CHAIN_LEN + 1);
  localparam int TIMEOUT_CYCLES = 2 * 2 * RUN_CYCLES;  // Two full runs, doubled

  localparam logic [23:0] STATIC_WORD = 24'h3CA108;   // Period 8, super pixel off

  logic        fw_axi_clk;
  logic        fw_rst_n;
  logic        fw_dev_id_enable;
  logic        fw_op_code_w_reset;
  logic        fw_op_code_w_cfg_static_0;
  logic        fw_op_code_r_cfg_static_0;
  logic        fw_op_code_w_cfg_array_0;
  logic        fw_op_code_r_cfg_array_0;
  logic        fw_op_code_r_data_array_0;
  logic        fw_op_code_w_status_clear;
  logic        fw_op_code_w_execute;
  logic [23:0] sw_write24_0;
  logic [31:0] fw_read_data32;
  logic [31:0] fw_read_status32;
  logic        fw_super_pixel_sel;
  logic        fw_config_clk;
  logic        fw_reset_not;
  logic        fw_config_in;
  logic        fw_config_load;
  logic        fw_config_out;

  logic [CFG_WORD_W-1:0] model [CFG_WORDS];      // Expected array contents
  int    err_cnt   = 0;
  int    check_cnt = 0;
  int    test_cnt  = 0;
  int    test_base = 0;                           // Errors before the current test
  int    cycle_cnt = 0;
  string cur_test  = "reset";

  fw_ip1 i_dut (.*);

  initial fw_axi_clk = 1'b0;
  always #2 fw_axi_clk = ~fw_axi_clk;             // 4 ns period

  //------------------------------------------------------------
  // Pin rules checked on every edge
  a_pins_idle: assert property (@(posedge fw_axi_clk) disable iff (!fw_rst_n)
    fw_config_load |-> (!fw_config_clk && !fw_config_in))
    else begin
      err_cnt++;
      $display("config clock or data toggled while load was high at %0t", $time);
    end

  a_reset_not_shift: assert property (@(posedge fw_axi_clk) disable iff (!fw_rst_n)
    !fw_reset_not |-> fw_config_load)
    else begin
      err_cnt++;
      $display("reset_not was low during shift mode at %0t", $time);
    end

  //------------------------------------------------------------
  // Stimulus helpers
  task automatic clear_ops();
    fw_op_code_w_reset        = 1'b0;
    fw_op_code_w_cfg_static_0 = 1'b0;
    fw_op_code_r_cfg_static_0 = 1'b0;
    fw_op_code_w_cfg_array_0  = 1'b0;
    fw_op_code_r_cfg_array_0  = 1'b0;
    fw_op_code_r_data_array_0 = 1'b0;
    fw_op_code_w_status_clear = 1'b0;
    fw_op_code_w_execute      = 1'b0;
  endtask

  // One-cycle pulse, data held until the strobe has acted
  task automatic issue_op(input int op, input logic [23:0] data);
    @(negedge fw_axi_clk);
    sw_write24_0 = data;
    case (op)
      OP_W_RESET:        fw_op_code_w_reset        = 1'b1;
      OP_W_STATIC:       fw_op_code_w_cfg_static_0 = 1'b1;
      OP_R_STATIC:       fw_op_code_r_cfg_static_0 = 1'b1;
      OP_W_ARRAY:        fw_op_code_w_cfg_array_0  = 1'b1;
      OP_R_ARRAY:        fw_op_code_r_cfg_array_0  = 1'b1;
      OP_R_DATA:         fw_op_code_r_data_array_0 = 1'b1;
      OP_W_STATUS_CLEAR: fw_op_code_w_status_clear = 1'b1;
      default:           fw_op_code_w_execute      = 1'b1;
    endcase
    @(negedge fw_axi_clk);
    clear_ops();
    @(negedge fw_axi_clk);                        // Strobe edge has passed
  endtask

  task automatic read_op(input int op, input logic [23:0] data, output logic [31:0] value);
    issue_op(op, data);
    @(negedge fw_axi_clk);                        // Two edges after the pulse
    value = fw_read_data32;
  endtask

  function automatic logic [23:0] make_exec(input int delay, input int sample,
                                            input logic loopback);
    logic [23:0] w;
    w = '0;
    w[X_DELAY_MSB:X_DELAY_LSB]       = PERIOD_W'(delay);
    w[X_SAMPLE_MSB:X_SAMPLE_LSB]     = PERIOD_W'(sample);
    w[X_TEST_NUM_MSB:X_TEST_NUM_LSB] = TEST_CFG_CHAIN;
    w[X_LOOPBACK]                    = loopback;   // Mask bit stays 0
    return w;
  endfunction

  // Execute and wait for ST_DONE, at most twice the run length
  task automatic run_chain(input logic [23:0] exec_word, output int low_cycles);
    int waited;
    waited     = 0;
    low_cycles = 0;
    issue_op(OP_EXECUTE, exec_word);
    while (!fw_read_status32[ST_DONE] && (waited < 2 * RUN_CYCLES)) begin
      @(negedge fw_axi_clk);
      waited++;
      if (!fw_reset_not) begin
        low_cycles++;
      end
    end
  endtask

  //------------------------------------------------------------
  // Checking and reporting
  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_cnt++;
    assert (actual === expected) else begin
      err_cnt++;
      $display("ERROR %s %s expected %h actual %h", cur_test, what, expected, actual);
    end
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_base = err_cnt;
    test_cnt++;
  endtask

  task automatic end_test();
    if (err_cnt == test_base) begin
      $display("test %0d %s ok", test_cnt, cur_test);
    end else begin
      $display("test %0d %s failed with %0d errors", test_cnt, cur_test, err_cnt - test_base);
    end
  endtask

  //------------------------------------------------------------
  // Watchdog
  initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge fw_axi_clk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles in %s, the DUT never finished", cycle_cnt, cur_test);
    $display("Simulation failed");
    $finish;
  end

  //------------------------------------------------------------
  // Test sequence
  initial begin
    logic [31:0] rd;
    logic [31:0] rnd;
    logic [7:0]  addr;
    int          low_cycles;
    int          polls;

    fw_rst_n         = 1'b0;
    fw_dev_id_enable = 1'b1;
    sw_write24_0     = '0;
    fw_config_out    = 1'b0;
    clear_ops();
    void'($urandom(32'hf3fb));
    repeat (3) @(posedge fw_axi_clk);
    @(negedge fw_axi_clk);
    fw_rst_n = 1'b1;

    // 1 Idle pins and empty status
    begin_test("idle_after_reset");
    @(negedge fw_axi_clk);
    check_value("config_clk", 32'd0, {31'b0, fw_config_clk});
    check_value("config_in", 32'd0, {31'b0, fw_config_in});
    check_value("super_pixel_sel", 32'd0, {31'b0, fw_super_pixel_sel});
    check_value("reset_not", 32'd1, {31'b0, fw_reset_not});
    check_value("config_load", 32'd1, {31'b0, fw_config_load});
    check_value("status", 32'd0, fw_read_status32);
    end_test();

    // 2 Static word round trip
    begin_test("static_rw");
    issue_op(OP_W_STATIC, STATIC_WORD);
    read_op(OP_R_STATIC, 24'h000000, rd);
    check_value("read data", {8'h00, STATIC_WORD}, rd);
    check_value("status", 32'h0000_0006, fw_read_status32);
    end_test();

    // 3 Random array words, read back as pairs
    begin_test("array_rw");
    for (int a = 0; a < CFG_WORDS; a++) begin
      rnd      = $urandom;
      model[a] = rnd[CFG_WORD_W-1:0];
      addr     = 8'(a + 8 * (a % 2));             // Odd words use an aliased address
      issue_op(OP_W_ARRAY, {addr, model[a]});
    end
    for (int a = 0; a < CFG_WORDS; a++) begin
      read_op(OP_R_ARRAY, {8'(a), 16'h0000}, rd);
      check_value($sformatf("pair %0d", a), {model[(a + 1) % CFG_WORDS], model[a]}, rd);
    end
    check_value("status", 32'h0000_001e, fw_read_status32);
    end_test();

    // 4 Loopback run returns the array in chain order
    begin_test("loopback_run");
    run_chain(make_exec(TB_DELAY, TB_SAMPLE, 1'b1), low_cycles);
    check_value("reset_not low cycles", TB_PERIOD, low_cycles);
    check_value("done bit", 32'd1, {31'b0, fw_read_status32[ST_DONE]});
    check_value("error bit", 32'd0, {31'b0, fw_read_status32[ST_ERROR]});
    for (int a = 0; a < DATA_WORDS; a++) begin
      read_op(OP_R_DATA, {8'(a), 16'h0000}, rd);
      check_value($sformatf("data %0d", a), {model[2 * a + 1], model[2 * a]}, rd);
    end
    read_op(OP_R_DATA, {8'(DATA_WORDS), 16'h0000}, rd);
    check_value("data past end", 32'd0, rd);
    end_test();

    // 5 Chip output of ones, then a bad delay
    begin_test("chip_run_and_error");
    issue_op(OP_W_RESET, 24'h000000);
    issue_op(OP_W_STATIC, STATIC_WORD);
    fw_config_out = 1'b1;                         // Chip returns ones
    run_chain(make_exec(TB_DELAY, TB_SAMPLE, 1'b0), low_cycles);
    check_value("reset_not low cycles", TB_PERIOD, low_cycles);
    check_value("done bit", 32'd1, {31'b0, fw_read_status32[ST_DONE]});
    for (int a = 0; a < DATA_WORDS; a++) begin
      read_op(OP_R_DATA, {8'(a), 16'h0000}, rd);
      check_value($sformatf("data %0d", a), 32'hffff_ffff, rd);
    end
    issue_op(OP_W_RESET, 24'h000000);
    issue_op(OP_W_STATIC, STATIC_WORD);
    issue_op(OP_EXECUTE, make_exec(1, TB_SAMPLE, 1'b0));  // Delay below the minimum
    polls = 0;
    while (!fw_read_status32[ST_ERROR] && (polls < TB_PERIOD)) begin
      @(negedge fw_axi_clk);
      polls++;
    end
    check_value("error bit", 32'd1, {31'b0, fw_read_status32[ST_ERROR]});
    issue_op(OP_W_RESET, 24'h000000);             // Stop the bad run
    fw_config_out = 1'b0;
    end_test();

    // 6 Status clear
    begin_test("status_clear");
    issue_op(OP_W_STATUS_CLEAR, 24'h000000);
    @(negedge fw_axi_clk);
    check_value("status", 32'd0, fw_read_status32);
    end_test();

    $display("tests %0d checks %0d errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== fw_ip1.sv ====
//------------------------------------------------------------
// IP1 slow control top level
// Opcode decode, config registers, config clock, chain test
// and software readout
//------------------------------------------------------------
`timescale 1ns/1ps

module fw_ip1 import fw_ip1_pkg::*; (
  input  logic        fw_axi_clk,
  input  logic        fw_rst_n,
  input  logic        fw_dev_id_enable,
  input  logic        fw_op_code_w_reset,
  input  logic        fw_op_code_w_cfg_static_0,
  input  logic        fw_op_code_r_cfg_static_0,
  input  logic        fw_op_code_w_cfg_array_0,
  input  logic        fw_op_code_r_cfg_array_0,
  input  logic        fw_op_code_r_data_array_0,
  input  logic        fw_op_code_w_status_clear,
  input  logic        fw_op_code_w_execute,
  input  logic [23:0] sw_write24_0,              // Data word from software
  output logic [31:0] fw_read_data32,
  output logic [31:0] fw_read_status32,
  output logic        fw_super_pixel_sel,        // Chip side
  output logic        fw_config_clk,
  output logic        fw_reset_not,
  output logic        fw_config_in,
  output logic        fw_config_load,
  input  logic        fw_config_out
);

  logic op_w_reset, op_w_static, op_r_static, op_w_array;
  logic op_r_array, op_r_data, op_status_clear, op_execute;
  logic test_enable, test_running, test_done, configclk;
  logic [23:0]                          static_word;
  logic [CFG_WORDS-1:0][CFG_WORD_W-1:0] cfg_array;
  logic [PERIOD_W-1:0]                  phase_cnt;
  logic [CHAIN_LEN-1:0]                 capture_reg;

  fw_op_decoder u_dec (
    .fw_axi_clk, .fw_rst_n, .fw_dev_id_enable,
    .fw_op_code_w_reset, .fw_op_code_w_cfg_static_0, .fw_op_code_r_cfg_static_0,
    .fw_op_code_w_cfg_array_0, .fw_op_code_r_cfg_array_0, .fw_op_code_r_data_array_0,
    .fw_op_code_w_status_clear, .fw_op_code_w_execute,
    .test_number (sw_write24_0[X_TEST_NUM_MSB:X_TEST_NUM_LSB]),
    .op_w_reset, .op_w_static, .op_r_static, .op_w_array,
    .op_r_array, .op_r_data, .op_status_clear, .op_execute, .test_enable
  );

  fw_cfg_regs u_regs (
    .fw_axi_clk, .fw_rst_n, .op_w_reset, .op_w_static, .op_w_array,
    .sw_write24_0, .static_word, .cfg_array
  );

  fw_configclk_gen u_clkgen (
    .fw_axi_clk, .fw_rst_n, .op_w_reset, .fw_dev_id_enable,
    .period (static_word[F_PERIOD_MSB:F_PERIOD_LSB]),
    .configclk, .phase_cnt
  );

  fw_cfg_chain_test u_test (
    .fw_axi_clk, .fw_rst_n, .op_w_reset, .op_execute, .test_enable,
    .configclk, .phase_cnt, .sw_write24_0, .static_word, .cfg_array, .fw_config_out,
    .fw_config_clk, .fw_reset_not, .fw_config_in, .fw_config_load, .fw_super_pixel_sel,
    .test_running, .test_done, .capture_reg
  );

  fw_readout u_rd (
    .fw_axi_clk, .fw_rst_n, .op_w_reset, .op_w_static, .op_r_static, .op_w_array,
    .op_r_array, .op_r_data, .op_status_clear, .op_execute,
    .sw_write24_0, .static_word, .cfg_array, .capture_reg,
    .test_running, .test_done, .fw_read_data32, .fw_read_status32
  );

endmodule

// ==== fw_readout.sv ====
//------------------------------------------------------------
// Software readout
// Registered read data multiplexer and the sticky status word
// with the execute configuration error flag
//------------------------------------------------------------
`timescale 1ns/1ps

module fw_readout import fw_ip1_pkg::*; (
  input  logic                                 fw_axi_clk,
  input  logic                                 fw_rst_n,
  input  logic                                 op_w_reset,
  input  logic                                 op_w_static,
  input  logic                                 op_r_static,
  input  logic                                 op_w_array,
  input  logic                                 op_r_array,
  input  logic                                 op_r_data,
  input  logic                                 op_status_clear,
  input  logic                                 op_execute,
  input  logic [23:0]                          sw_write24_0,
  input  logic [23:0]                          static_word,
  input  logic [CFG_WORDS-1:0][CFG_WORD_W-1:0] cfg_array,
  input  logic [CHAIN_LEN-1:0]                 capture_reg,
  input  logic                                 test_running,
  input  logic                                 test_done,
  output logic [31:0]                          fw_read_data32,
  output logic [31:0]                          fw_read_status32
);

  logic [7:0]          addr;                     // Read address byte
  logic [CFG_AW-1:0]   a_lo;
  logic [CFG_AW-1:0]   a_hi;                     // Wraps past the last word
  logic [PERIOD_W-1:0] delay;
  logic [PERIOD_W-1:0] period;
  logic                cfg_err;

  assign addr    = sw_write24_0[A_ADDR_MSB:A_ADDR_LSB];
  assign a_lo    = addr[CFG_AW-1:0];
  assign a_hi    = a_lo + 1'b1;
  assign delay   = sw_write24_0[X_DELAY_MSB:X_DELAY_LSB];
  assign period  = static_word[F_PERIOD_MSB:F_PERIOD_LSB];
  assign cfg_err = test_running && ((delay < MIN_DELAY) || (delay > period));

  // Read data holds until the next read
  always_ff @(posedge fw_axi_clk or negedge fw_rst_n) begin
    if (!fw_rst_n) begin
      fw_read_data32 <= '0;
    end else if (op_r_static) begin
      fw_read_data32 <= {8'h00, static_word};
    end else if (op_r_array) begin
      fw_read_data32 <= {cfg_array[a_hi], cfg_array[a_lo]};  // Word pair a+1, a
    end else if (op_r_data) begin
      if (addr < DATA_WORDS) begin
        fw_read_data32 <= capture_reg[32*addr[DATA_AW-1:0] +: 32];
      end else begin
        fw_read_data32 <= '0;                    // Beyond the capture register
      end
    end
  end

  //------------------------------------------------------------
  // Sticky status, clear takes priority
  always_ff @(posedge fw_axi_clk or negedge fw_rst_n) begin
    if (!fw_rst_n) begin
      fw_read_status32 <= '0;
    end else if (op_status_clear) begin
      fw_read_status32 <= '0;
    end else begin
      if (op_w_reset)  fw_read_status32[ST_W_RESET]  <= 1'b1;
      if (op_w_static) fw_read_status32[ST_W_STATIC] <= 1'b1;
      if (op_r_static) fw_read_status32[ST_R_STATIC] <= 1'b1;
      if (op_w_array)  fw_read_status32[ST_W_ARRAY]  <= 1'b1;
      if (op_r_array)  fw_read_status32[ST_R_ARRAY]  <= 1'b1;
      if (op_r_data)   fw_read_status32[ST_R_DATA]   <= 1'b1;
      if (op_execute)  fw_read_status32[ST_EXECUTE]  <= 1'b1;
      fw_read_status32[ST_DONE] <= test_done;    // Follows the test
      if (cfg_err)     fw_read_status32[ST_ERROR]    <= 1'b1;
    end
  end

endmodule

// ==== fw_cfg_chain_test.sv ====
//------------------------------------------------------------
// Configuration chain test
// Shifts the config array into the chip on the config clock
// and samples the chip's serial output into a capture register
// Loopback captures config_in instead of config_out
//------------------------------------------------------------
`timescale 1ns/1ps

module fw_cfg_chain_test import fw_ip1_pkg::*; (
  input  logic                                 fw_axi_clk,
  input  logic                                 fw_rst_n,
  input  logic                                 op_w_reset,
  input  logic                                 op_execute,
  input  logic                                 test_enable,
  input  logic                                 configclk,
  input  logic [PERIOD_W-1:0]                  phase_cnt,
  input  logic [23:0]                          sw_write24_0,
  input  logic [23:0]                          static_word,
  input  logic [CFG_WORDS-1:0][CFG_WORD_W-1:0] cfg_array,
  input  logic                                 fw_config_out,   // Serial out of the chip
  output logic                                 fw_config_clk,
  output logic                                 fw_reset_not,
  output logic                                 fw_config_in,
  output logic                                 fw_config_load,  // Low selects shift mode
  output logic                                 fw_super_pixel_sel,
  output logic                                 test_running,
  output logic                                 test_done,
  output logic [CHAIN_LEN-1:0]                 capture_reg
);

  test_state_t          state;
  logic [PERIOD_W-1:0]  delay_q;                 // Phase where the run starts
  logic [PERIOD_W-1:0]  sample_q;                // Phase where a bit is captured
  logic                 loopback_q;
  logic                 mask_rst_q;
  logic [CHAIN_LEN-1:0] tx_reg;                  // Bit 0 drives config_in
  logic [CNT_W-1:0]     shift_cnt;
  logic                 shift_tick;
  logic                 sample_tick;
  logic                 bit_in;

  assign shift_tick  = (state == SHIFT) && (phase_cnt == '0);
  assign sample_tick = (state == SHIFT) && (phase_cnt == sample_q);
  assign bit_in      = loopback_q ? fw_config_in : fw_config_out;

  //------------------------------------------------------------
  // Execute parameters, taken only while idle
  always_ff @(posedge fw_axi_clk or negedge fw_rst_n) begin
    if (!fw_rst_n) begin
      delay_q    <= '0;
      sample_q   <= '0;
      loopback_q <= 1'b0;
      mask_rst_q <= 1'b0;
    end else if (op_execute && (state == IDLE)) begin
      delay_q    <= sw_write24_0[X_DELAY_MSB:X_DELAY_LSB];
      sample_q   <= sw_write24_0[X_SAMPLE_MSB:X_SAMPLE_LSB];
      loopback_q <= sw_write24_0[X_LOOPBACK];
      mask_rst_q <= sw_write24_0[X_MASK_RESET_NOT];
    end
  end

  //------------------------------------------------------------
  // Test FSM
  always_ff @(posedge fw_axi_clk or negedge fw_rst_n) begin
    if (!fw_rst_n) begin
      state     <= IDLE;
      shift_cnt <= '0;
    end else if (op_w_reset) begin
      state     <= IDLE;
      shift_cnt <= '0;
    end else begin
      case (state)
        IDLE: if (test_enable) begin
          state     <= DELAY;
          shift_cnt <= '0;
        end
        DELAY:     if (phase_cnt == delay_q) state <= RESET_NOT;
        RESET_NOT: if (phase_cnt == delay_q) state <= SHIFT;    // One full period
        SHIFT: if (shift_tick) begin
          shift_cnt <= shift_cnt + 1'b1;
          if (shift_cnt == CNT_W'(CHAIN_LEN - 1)) state <= DONE;
        end
        DONE:    state <= DONE;                  // Until the next reset op
        default: state <= IDLE;
      endcase
    end
  end

  // Transmit chain, word 0 leaves first
  always_ff @(posedge fw_axi_clk) begin
    if (op_execute && (state == IDLE)) begin
      tx_reg <= cfg_array;
    end else if (shift_tick) begin
      tx_reg <= {1'b0, tx_reg[CHAIN_LEN-1:1]};
    end
  end

  // Capture, first sampled bit ends in bit 0
  always_ff @(posedge fw_axi_clk) begin
    if (sample_tick) begin
      capture_reg <= {bit_in, capture_reg[CHAIN_LEN-1:1]};
    end
  end

  //------------------------------------------------------------
  // Chip pins, idle levels whenever no test is enabled
  assign fw_config_clk      = test_enable & (state == SHIFT) & configclk;
  assign fw_config_in       = test_enable & (state == SHIFT) & tx_reg[0];
  assign fw_reset_not       = ~(test_enable & (state == RESET_NOT) & ~mask_rst_q);
  assign fw_config_load     = ~(test_enable & (state == SHIFT));
  assign fw_super_pixel_sel = test_enable & static_word[F_SUPER_PIX];
  assign test_running       = (state == DELAY) || (state == RESET_NOT) || (state == SHIFT);
  assign test_done          = (state == DONE);

  a_shift_bound: assert property (@(posedge fw_axi_clk) disable iff (!fw_rst_n)
    shift_cnt <= CHAIN_LEN);

endmodule

// ==== fw_configclk_gen.sv ====
//------------------------------------------------------------
// Configuration clock generator
// Phase counter with a software period, high for the upper
// half of each period
//------------------------------------------------------------
`timescale 1ns/1ps

module fw_configclk_gen import fw_ip1_pkg::*; (
  input  logic                fw_axi_clk,
  input  logic                fw_rst_n,
  input  logic                op_w_reset,
  input  logic                fw_dev_id_enable,
  input  logic [PERIOD_W-1:0] period,           // In fw_axi_clk cycles
  output logic                configclk,
  output logic [PERIOD_W-1:0] phase_cnt         // 0 to period minus 1
);

  logic [PERIOD_W-1:0] cnt_nxt;

  // Wrap once the count reaches period minus 1
  always_comb begin
    if (({1'b0, phase_cnt} + 1'b1) >= {1'b0, period}) begin
      cnt_nxt = '0;
    end else begin
      cnt_nxt = phase_cnt + 1'b1;
    end
  end

  always_ff @(posedge fw_axi_clk or negedge fw_rst_n) begin
    if (!fw_rst_n) begin
      phase_cnt <= '0;
      configclk <= 1'b0;
    end else if (op_w_reset || !fw_dev_id_enable) begin
      phase_cnt <= '0;                           // Held while disabled
      configclk <= 1'b0;
    end else begin
      phase_cnt <= cnt_nxt;
      configclk <= (period > 1) && (cnt_nxt >= (period >> 1));  // No clock below period 2
    end
  end

endmodule

// ==== fw_cfg_regs.sv ====
//------------------------------------------------------------
// Configuration registers
// Static configuration word and the configuration word array,
// both written by software and cleared by the reset op
//------------------------------------------------------------
`timescale 1ns/1ps

module fw_cfg_regs import fw_ip1_pkg::*; (
  input  logic                                 fw_axi_clk,
  input  logic                                 fw_rst_n,
  input  logic                                 op_w_reset,
  input  logic                                 op_w_static,
  input  logic                                 op_w_array,
  input  logic [23:0]                          sw_write24_0,
  output logic [23:0]                          static_word,
  output logic [CFG_WORDS-1:0][CFG_WORD_W-1:0] cfg_array
);

  logic [CFG_AW-1:0] w_addr;                     // Array address modulo CFG_WORDS

  assign w_addr = sw_write24_0[A_ADDR_LSB +: CFG_AW];

  //------------------------------------------------------------
  // Static word, holds period and super pixel select
  always_ff @(posedge fw_axi_clk or negedge fw_rst_n) begin
    if (!fw_rst_n) begin
      static_word <= '0;
    end else if (op_w_reset) begin
      static_word <= '0;
    end else if (op_w_static) begin
      static_word <= sw_write24_0;
    end
  end

  //------------------------------------------------------------
  // Config array, one 16-bit word per write
  always_ff @(posedge fw_axi_clk) begin
    if (op_w_reset) begin
      cfg_array <= '0;
    end else if (op_w_array) begin
      cfg_array[w_addr] <= sw_write24_0[CFG_WORD_W-1:0];  // Low half carries the data
    end
  end

endmodule

// ==== fw_op_decoder.sv ====
//------------------------------------------------------------
// Opcode decoder
// Gates the software opcode pulses with the device enable,
// registers them into strobes and holds the test enable
//------------------------------------------------------------
`timescale 1ns/1ps

module fw_op_decoder import fw_ip1_pkg::*; (
  input  logic       fw_axi_clk,
  input  logic       fw_rst_n,
  input  logic       fw_dev_id_enable,          // This block is addressed
  input  logic       fw_op_code_w_reset,
  input  logic       fw_op_code_w_cfg_static_0,
  input  logic       fw_op_code_r_cfg_static_0,
  input  logic       fw_op_code_w_cfg_array_0,
  input  logic       fw_op_code_r_cfg_array_0,
  input  logic       fw_op_code_r_data_array_0,
  input  logic       fw_op_code_w_status_clear,
  input  logic       fw_op_code_w_execute,
  input  logic [3:0] test_number,               // Test field of the execute word
  output logic       op_w_reset,
  output logic       op_w_static,
  output logic       op_r_static,
  output logic       op_w_array,
  output logic       op_r_array,
  output logic       op_r_data,
  output logic       op_status_clear,
  output logic       op_execute,
  output logic       test_enable                // Level, set by execute of test 1
);

  always_ff @(posedge fw_axi_clk or negedge fw_rst_n) begin
    if (!fw_rst_n) begin
      op_w_reset      <= 1'b0;
      op_w_static     <= 1'b0;
      op_r_static     <= 1'b0;
      op_w_array      <= 1'b0;
      op_r_array      <= 1'b0;
      op_r_data       <= 1'b0;
      op_status_clear <= 1'b0;
      op_execute      <= 1'b0;
    end else begin
      op_w_reset      <= fw_dev_id_enable & fw_op_code_w_reset;
      op_w_static     <= fw_dev_id_enable & fw_op_code_w_cfg_static_0;
      op_r_static     <= fw_dev_id_enable & fw_op_code_r_cfg_static_0;
      op_w_array      <= fw_dev_id_enable & fw_op_code_w_cfg_array_0;
      op_r_array      <= fw_dev_id_enable & fw_op_code_r_cfg_array_0;
      op_r_data       <= fw_dev_id_enable & fw_op_code_r_data_array_0;
      op_status_clear <= fw_dev_id_enable & fw_op_code_w_status_clear;
      op_execute      <= fw_dev_id_enable & fw_op_code_w_execute;
    end
  end

  // Test enable stays up until the next reset op
  always_ff @(posedge fw_axi_clk or negedge fw_rst_n) begin
    if (!fw_rst_n) begin
      test_enable <= 1'b0;
    end else if (op_w_reset) begin
      test_enable <= 1'b0;
    end else if (op_execute && (test_number == TEST_CFG_CHAIN)) begin
      test_enable <= 1'b1;
    end
  end

  // Software issues one opcode at a time
  a_one_strobe: assert property (@(posedge fw_axi_clk) disable iff (!fw_rst_n)
    $onehot0({op_w_reset, op_w_static, op_r_static, op_w_array,
              op_r_array, op_r_data, op_status_clear, op_execute}));

endmodule

// ==== fw_ip1_pkg.sv ====
//------------------------------------------------------------
// IP1 slow control shared definitions
// Chain sizes, static and execute word fields, status bit
// positions and the configuration test state type
//------------------------------------------------------------
package fw_ip1_pkg;

  //------------------------------------------------------------
  // Configuration chain sizes
  localparam int CFG_WORDS  = 8;                        // Words in the config array
  localparam int CFG_WORD_W = 16;                       // Bits per array word
  localparam int CHAIN_LEN  = CFG_WORDS * CFG_WORD_W;   // Serial chain, 128 bits
  localparam int DATA_WORDS = CHAIN_LEN / 32;           // 32-bit capture words
  localparam int PERIOD_W   = 7;                        // Config clock period field
  localparam int CFG_AW     = $clog2(CFG_WORDS);        // Array index width
  localparam int DATA_AW    = $clog2(DATA_WORDS);       // Capture word index width
  localparam int CNT_W      = $clog2(CHAIN_LEN + 1);    // Shift counter, 0 to CHAIN_LEN

  //------------------------------------------------------------
  // Static word fields
  localparam int F_PERIOD_LSB = 0;
  localparam int F_PERIOD_MSB = 6;
  localparam int F_SUPER_PIX  = 7;

  // Execute word fields, the address shares the upper byte
  localparam int X_DELAY_LSB      = 0;
  localparam int X_DELAY_MSB      = 6;
  localparam int X_SAMPLE_LSB     = 7;
  localparam int X_SAMPLE_MSB     = 13;
  localparam int X_TEST_NUM_LSB   = 14;
  localparam int X_TEST_NUM_MSB   = 17;
  localparam int X_LOOPBACK       = 18;
  localparam int X_MASK_RESET_NOT = 23;                 // Keep reset_not high
  localparam int A_ADDR_LSB       = 16;                 // Array or readout address
  localparam int A_ADDR_MSB       = 23;

  localparam logic [3:0] TEST_CFG_CHAIN = 4'd1;         // Only test kept
  localparam int         MIN_DELAY      = 3;            // Smallest legal delay

  //------------------------------------------------------------
  // Sticky status bits
  localparam int ST_W_RESET = 0, ST_W_STATIC = 1, ST_R_STATIC = 2, ST_W_ARRAY = 3;
  localparam int ST_R_ARRAY = 4, ST_R_DATA = 5, ST_EXECUTE = 6, ST_DONE = 7, ST_ERROR = 31;

  typedef enum logic [2:0] {IDLE, DELAY, RESET_NOT, SHIFT, DONE} test_state_t;

endpackage
